// ==== fifo_host_pkg.sv ====
package fifo_host_pkg;

    // ==========================================================
    // Widths
    // ==========================================================

    // A cache line is carved into 32-bit message chunks
    localparam int CHUNK_WIDTH = 32;
    localparam int CHUNKS_PER_LINE = 4;
    localparam int LINE_WIDTH = CHUNK_WIDTH * CHUNKS_PER_LINE;

    // The ring holds 64 lines so a 6-bit index wraps on its own
    localparam int RING_IDX_WIDTH = 6;
    localparam int LINE_ADDR_WIDTH = 32;

    // The payload count lives in the low half of the header chunk
    localparam int MSG_COUNT_WIDTH = 16;

    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 3;

    // Default number of reads that may be in flight at once
    localparam int SB_DEPTH_DEFAULT = 8;

    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [CHUNK_WIDTH-1:0] chunk_t;
    typedef logic [$clog2(CHUNKS_PER_LINE)-1:0] chunk_idx_t;
    typedef logic [RING_IDX_WIDTH-1:0] ring_idx_t;
    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [MSG_COUNT_WIDTH-1:0] msg_count_t;
    typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;

    // ==========================================================
    // Register map, word addresses on the Wishbone port
    // ==========================================================

    localparam wb_addr_t REG_CTRL = 3'd0;
    localparam wb_addr_t REG_BASE = 3'd1;
    localparam wb_addr_t REG_NEWEST = 3'd2;
    localparam wb_addr_t REG_OLDEST = 3'd3;
    localparam wb_addr_t REG_REQ_COUNT = 3'd4;
    localparam wb_addr_t REG_RSP_COUNT = 3'd5;

    // States of the line-to-chunk unpacker
    typedef enum logic [1:0]
    {
        st_new_message,
        st_read_header,
        st_new_line,
        st_valid_chunk
    } reader_state_t;

endpackage

// ==== fifo_host_csr.sv ====
`timescale 1ns/1ps

module fifo_host_csr
(
    input  logic                      clk,
    input  logic                      resetb,

    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  fifo_host_pkg::wb_addr_t   wb_adr,
    input  fifo_host_pkg::wb_data_t   wb_dat_i,
    output fifo_host_pkg::wb_data_t   wb_dat_o,
    output logic                      wb_ack,

    input  fifo_host_pkg::ring_idx_t  oldest_idx,
    input  logic                      rd_req,
    input  logic                      rd_grant,
    input  logic                      rd_rsp_valid,

    output logic                      enable,
    output fifo_host_pkg::line_addr_t base_addr,
    output fifo_host_pkg::ring_idx_t  newest_idx
);

    // A classic cycle is served once, in the cycle before ack goes high
    logic access;
    fifo_host_pkg::wb_data_t rd_mux;
    fifo_host_pkg::wb_data_t req_count;
    fifo_host_pkg::wb_data_t rsp_count;

    assign access = wb_cyc && wb_stb && !wb_ack;

    // Ack is a single-cycle pulse because it blocks a second access
    always_ff @(posedge clk)
    begin
        if (!resetb)
            wb_ack <= 1'b0;
        else
            wb_ack <= access;
    end

    // ==========================================================
    // Control registers
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            enable <= 1'b0;
            base_addr <= '0;
            newest_idx <= '0;
        end
        else if (access && wb_we)
        begin
            // OLDEST and the counters are status only, so those writes fall through
            case (wb_adr)
                fifo_host_pkg::REG_CTRL:   enable <= wb_dat_i[0];
                fifo_host_pkg::REG_BASE:   base_addr <= fifo_host_pkg::line_addr_t'(wb_dat_i);
                fifo_host_pkg::REG_NEWEST: newest_idx <= fifo_host_pkg::ring_idx_t'(wb_dat_i);
                default:                   ;
            endcase
        end
    end

    // Accepted requests and returned responses, for the host to compare
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            req_count <= '0;
            rsp_count <= '0;
        end
        else
        begin
            if (rd_req && rd_grant)
                req_count <= req_count + 1'b1;
            if (rd_rsp_valid)
                rsp_count <= rsp_count + 1'b1;
        end
    end

    // ==========================================================
    // Read path
    // ==========================================================

    always_comb
    begin
        case (wb_adr)
            fifo_host_pkg::REG_CTRL:      rd_mux = {31'b0, enable};
            fifo_host_pkg::REG_BASE:      rd_mux = fifo_host_pkg::wb_data_t'(base_addr);
            fifo_host_pkg::REG_NEWEST:    rd_mux = fifo_host_pkg::wb_data_t'(newest_idx);
            fifo_host_pkg::REG_OLDEST:    rd_mux = fifo_host_pkg::wb_data_t'(oldest_idx);
            fifo_host_pkg::REG_REQ_COUNT: rd_mux = req_count;
            fifo_host_pkg::REG_RSP_COUNT: rd_mux = rsp_count;
            default:                      rd_mux = '0;
        endcase
    end

    // Read data is captured on the same edge that raises ack
    always_ff @(posedge clk)
    begin
        if (access)
            wb_dat_o <= rd_mux;
    end

endmodule

// ==== fifo_host_scoreboard.sv ====
`timescale 1ns/1ps

module fifo_host_scoreboard
#(
    parameter int N_ENTRIES = fifo_host_pkg::SB_DEPTH_DEFAULT
)
(
    input  logic                         clk,
    input  logic                         resetb,

    // Slot allocation, one per accepted read request
    input  logic                         alloc,
    output logic                         not_full,
    output logic [$clog2(N_ENTRIES)-1:0] alloc_idx,

    // Response data, written by tag in any order
    input  logic                         enq_en,
    input  logic [$clog2(N_ENTRIES)-1:0] enq_idx,
    input  fifo_host_pkg::line_t         enq_data,

    // In-order release of the oldest slot
    input  logic                         deq,
    output logic                         not_empty,
    output fifo_host_pkg::line_t         head_line
);

    localparam int IDX_W = $clog2(N_ENTRIES);
    localparam int CNT_W = $clog2(N_ENTRIES + 1);

    typedef logic [IDX_W-1:0] slot_t;
    typedef logic [CNT_W-1:0] count_t;

    // Line storage and a per-slot flag that says its response is in
    fifo_host_pkg::line_t mem [N_ENTRIES];
    logic [N_ENTRIES-1:0] filled;

    slot_t head;
    slot_t tail;
    count_t count;
    logic do_alloc;
    logic do_deq;

    // Pointers wrap by hand so that depths other than powers of two work
    function automatic slot_t next_slot(input slot_t s);
        if (s == slot_t'(N_ENTRIES - 1))
            return '0;
        else
            return s + slot_t'(1);
    endfunction

    assign not_full = (count != count_t'(N_ENTRIES));
    assign alloc_idx = tail;

    // The head is only released once its own response has arrived
    assign not_empty = filled[head];
    assign head_line = mem[head];

    assign do_alloc = alloc && not_full;
    assign do_deq = deq && not_empty;

    // ==========================================================
    // Occupancy tracking
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end
        else
        begin
            if (do_alloc)
                tail <= next_slot(tail);
            if (do_deq)
                head <= next_slot(head);

            case ({do_alloc, do_deq})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

    // A slot being freed is never the slot of an incoming response
    always_ff @(posedge clk)
    begin
        if (!resetb)
            filled <= '0;
        else
        begin
            if (do_deq)
                filled[head] <= 1'b0;
            if (enq_en)
                filled[enq_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[enq_idx] <= enq_data;
    end

endmodule

// ==== fifo_host_reader.sv ====
`timescale 1ns/1ps

module fifo_host_reader
#(
    parameter int SB_ENTRIES = fifo_host_pkg::SB_DEPTH_DEFAULT
)
(
    input  logic                          clk,
    input  logic                          resetb,

    // Steering from the register block
    input  logic                          enable,
    input  fifo_host_pkg::line_addr_t     base_addr,
    input  fifo_host_pkg::ring_idx_t      newest_idx,
    output fifo_host_pkg::ring_idx_t      oldest_idx,

    // Memory read requests
    output logic                          rd_req,
    input  logic                          rd_grant,
    output fifo_host_pkg::line_addr_t     rd_addr,
    output logic [$clog2(SB_ENTRIES)-1:0] rd_tag,

    // Tagged responses, possibly out of order
    input  logic                          rd_rsp_valid,
    input  logic [$clog2(SB_ENTRIES)-1:0] rd_rsp_tag,
    input  fifo_host_pkg::line_t          rd_rsp_data,

    // Client chunk stream
    output fifo_host_pkg::chunk_t         rx_data,
    output logic                          rx_rdy,
    input  logic                          rx_enable
);

    localparam int TAG_W = $clog2(SB_ENTRIES);
    localparam int CW = fifo_host_pkg::CHUNK_WIDTH;
    localparam int LW = fifo_host_pkg::LINE_WIDTH;

    typedef logic [TAG_W-1:0] slot_t;

    // Ring slot of the next line to request
    fifo_host_pkg::ring_idx_t next_req_idx;
    logic req_accept;

    fifo_host_pkg::reader_state_t state;
    fifo_host_pkg::line_t cur_line;
    fifo_host_pkg::line_t cur_line_rot;
    fifo_host_pkg::msg_count_t num_chunks;
    fifo_host_pkg::chunk_idx_t chunk_in_line;

    logic sb_not_full;
    logic sb_not_empty;
    logic sb_deq;
    slot_t sb_alloc_idx;
    fifo_host_pkg::line_t sb_head_line;

    // ==========================================================
    // Request issue
    // ==========================================================

    // Stop at the host's newest index and when every scoreboard slot is taken
    assign rd_req = enable && (next_req_idx != newest_idx) && sb_not_full;
    assign req_accept = rd_req && rd_grant;

    // Adding the index keeps the ring free of any alignment need on base
    assign rd_addr = base_addr + fifo_host_pkg::line_addr_t'(next_req_idx);
    assign rd_tag = sb_alloc_idx;

    always_ff @(posedge clk)
    begin
        if (!resetb)
            next_req_idx <= '0;
        else if (req_accept)
            next_req_idx <= next_req_idx + 1'b1;
    end

    // Slots become free for the host as lines leave the scoreboard in order
    always_ff @(posedge clk)
    begin
        if (!resetb)
            oldest_idx <= '0;
        else if (sb_deq)
            oldest_idx <= oldest_idx + 1'b1;
    end

    fifo_host_scoreboard #(.N_ENTRIES(SB_ENTRIES)) scoreboard_inst
    (
        .clk       (clk),
        .resetb    (resetb),
        .alloc     (req_accept),
        .not_full  (sb_not_full),
        .alloc_idx (sb_alloc_idx),
        .enq_en    (rd_rsp_valid),
        .enq_idx   (rd_rsp_tag),
        .enq_data  (rd_rsp_data),
        .deq       (sb_deq),
        .not_empty (sb_not_empty),
        .head_line (sb_head_line)
    );

    // ==========================================================
    // Line-to-chunk unpacker
    // ==========================================================

    // A line is taken only in the two states that wait for one
    assign sb_deq = sb_not_empty &&
                    ((state == fifo_host_pkg::st_new_message) ||
                     (state == fifo_host_pkg::st_new_line));

    // The chunk on offer always sits in the low word of the line
    assign cur_line_rot = {cur_line[CW-1:0], cur_line[LW-1:CW]};
    assign rx_data = cur_line[CW-1:0];
    assign rx_rdy = (state == fifo_host_pkg::st_valid_chunk);

    always_ff @(posedge clk)
    begin
        if (!resetb)
            state <= fifo_host_pkg::st_new_message;
        else
        begin
            case (state)
                fifo_host_pkg::st_new_message:
                    if (sb_not_empty)
                        state <= fifo_host_pkg::st_read_header;
                fifo_host_pkg::st_read_header:
                    state <= fifo_host_pkg::st_valid_chunk;
                fifo_host_pkg::st_new_line:
                    if (sb_not_empty)
                        state <= fifo_host_pkg::st_valid_chunk;
                fifo_host_pkg::st_valid_chunk:
                    if (rx_enable)
                    begin
                        // End of message wins, and any chunks left in the line are dropped
                        if (num_chunks == fifo_host_pkg::msg_count_t'(1))
                            state <= fifo_host_pkg::st_new_message;
                        else if (chunk_in_line ==
                                 fifo_host_pkg::chunk_idx_t'(fifo_host_pkg::CHUNKS_PER_LINE - 1))
                            state <= fifo_host_pkg::st_new_line;
                    end
            endcase
        end
    end

    // Current line, payload count and position within the line
    always_ff @(posedge clk)
    begin
        case (state)
            fifo_host_pkg::st_new_message:
                if (sb_deq)
                    cur_line <= sb_head_line;
            fifo_host_pkg::st_read_header:
            begin
                // Header chunk gives the count and is rotated out of view
                num_chunks <= cur_line[fifo_host_pkg::MSG_COUNT_WIDTH-1:0];
                chunk_in_line <= fifo_host_pkg::chunk_idx_t'(1);
                cur_line <= cur_line_rot;
            end
            fifo_host_pkg::st_new_line:
                if (sb_deq)
                begin
                    cur_line <= sb_head_line;
                    chunk_in_line <= '0;
                end
            fifo_host_pkg::st_valid_chunk:
                if (rx_enable)
                begin
                    num_chunks <= num_chunks - 1'b1;
                    chunk_in_line <= chunk_in_line + 1'b1;
                    cur_line <= cur_line_rot;
                end
        endcase
    end

endmodule

// ==== fifo_host_top.sv ====
`timescale 1ns/1ps

module fifo_host_top
#(
    parameter int SB_ENTRIES = fifo_host_pkg::SB_DEPTH_DEFAULT
)
(
    input  logic                          clk,
    input  logic                          resetb,

    // Wishbone classic register port
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  fifo_host_pkg::wb_addr_t       wb_adr,
    input  fifo_host_pkg::wb_data_t       wb_dat_i,
    output fifo_host_pkg::wb_data_t       wb_dat_o,
    output logic                          wb_ack,

    // Memory read requests
    output logic                          rd_req,
    input  logic                          rd_grant,
    output fifo_host_pkg::line_addr_t     rd_addr,
    output logic [$clog2(SB_ENTRIES)-1:0] rd_tag,

    // Memory read responses
    input  logic                          rd_rsp_valid,
    input  logic [$clog2(SB_ENTRIES)-1:0] rd_rsp_tag,
    input  fifo_host_pkg::line_t          rd_rsp_data,

    // Client chunk stream
    output fifo_host_pkg::chunk_t         rx_data,
    output logic                          rx_rdy,
    input  logic                          rx_enable
);

    // Register block to reader steering and the oldest index coming back
    logic enable;
    fifo_host_pkg::line_addr_t base_addr;
    fifo_host_pkg::ring_idx_t newest_idx;
    fifo_host_pkg::ring_idx_t oldest_idx;

    fifo_host_csr csr_inst
    (
        .clk          (clk),
        .resetb       (resetb),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack),
        .oldest_idx   (oldest_idx),
        .rd_req       (rd_req),
        .rd_grant     (rd_grant),
        .rd_rsp_valid (rd_rsp_valid),
        .enable       (enable),
        .base_addr    (base_addr),
        .newest_idx   (newest_idx)
    );

    fifo_host_reader #(.SB_ENTRIES(SB_ENTRIES)) reader_inst
    (
        .clk          (clk),
        .resetb       (resetb),
        .enable       (enable),
        .base_addr    (base_addr),
        .newest_idx   (newest_idx),
        .oldest_idx   (oldest_idx),
        .rd_req       (rd_req),
        .rd_grant     (rd_grant),
        .rd_addr      (rd_addr),
        .rd_tag       (rd_tag),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_tag   (rd_rsp_tag),
        .rd_rsp_data  (rd_rsp_data),
        .rx_data      (rx_data),
        .rx_rdy       (rx_rdy),
        .rx_enable    (rx_enable)
    );

endmodule

// ==== fifo_host_props.sv ====
`timescale 1ns/1ps

module fifo_host_props
(
    input logic                  clk,
    input logic                  resetb,
    input logic                  rd_req,
    input logic                  rd_grant,
    input logic                  rx_rdy,
    input logic                  rx_enable,
    input fifo_host_pkg::chunk_t rx_data,
    input logic                  wb_ack
);

    // The memory may only grant a request that is on offer
    grant_needs_req: assert property (@(posedge clk) disable iff (!resetb)
        rd_grant |-> rd_req)
        else $error("rd_grant high without rd_req");

    // The client takes a chunk only while one is offered
    enable_needs_rdy: assert property (@(posedge clk) disable iff (!resetb)
        rx_enable |-> rx_rdy)
        else $error("rx_enable high without rx_rdy");

    ack_single_cycle: assert property (@(posedge clk) disable iff (!resetb)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held longer than one cycle");

    // A stalled chunk holds its value into the next cycle
    data_stable_on_stall: assert property (@(posedge clk) disable iff (!resetb)
        (rx_rdy && !rx_enable) |=> $stable(rx_data))
        else $error("rx_data changed while stalled");

endmodule

bind fifo_host_top fifo_host_props props_inst
(
    .clk       (clk),
    .resetb    (resetb),
    .rd_req    (rd_req),
    .rd_grant  (rd_grant),
    .rx_rdy    (rx_rdy),
    .rx_enable (rx_enable),
    .rx_data   (rx_data),
    .wb_ack    (wb_ack)
);

// ==== tb_fifo_host.sv ====
`timescale 1ns/1ps

module tb_fifo_host;

    localparam int SB_DEPTH = fifo_host_pkg::SB_DEPTH_DEFAULT;
    localparam int TAG_W = $clog2(SB_DEPTH);
    localparam int NUM_MSGS = 30;
    localparam int MAX_PAYLOAD = 12;
    localparam int CYCLES_PER_MSG = 200;
    localparam int SETUP_CYCLES = 500;
    localparam int WATCHDOG_CYCLES = NUM_MSGS * CYCLES_PER_MSG + SETUP_CYCLES;
    localparam int PAUSE_MSG = 10;
    localparam int PAUSE_CYCLES = 50;
    localparam int WB_TIMEOUT = 16;
    localparam int RESUME_TIMEOUT = 500;

    logic clk;
    logic resetb;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    fifo_host_pkg::wb_addr_t wb_adr;
    fifo_host_pkg::wb_data_t wb_dat_i;
    fifo_host_pkg::wb_data_t wb_dat_o;
    logic wb_ack;
    logic rd_req;
    logic rd_grant;
    fifo_host_pkg::line_addr_t rd_addr;
    logic [TAG_W-1:0] rd_tag;
    logic rd_rsp_valid;
    logic [TAG_W-1:0] rd_rsp_tag;
    fifo_host_pkg::line_t rd_rsp_data;
    fifo_host_pkg::chunk_t rx_data;
    logic rx_rdy;
    logic rx_enable;

    // Random willingness of the memory and the client, gated so neither can
    // answer a handshake that is not on offer
    logic grant_roll;
    logic take_roll;
    assign rd_grant = rd_req && grant_roll;
    assign rx_enable = rx_rdy && take_roll;

    integer seed;
    int cycle;

    // ==========================================================
    // Host memory and expected traffic
    // ==========================================================

    fifo_host_pkg::line_t host_mem [64];
    fifo_host_pkg::line_t all_lines [$];
    int msg_len [NUM_MSGS];
    int total_lines;
    fifo_host_pkg::chunk_t exp_chunk [$];
    int exp_line [$];
    fifo_host_pkg::line_addr_t base_val;
    fifo_host_pkg::ring_idx_t wr_idx;
    int published_total;

    // Reads in flight inside the memory model
    logic [TAG_W-1:0] pend_tag [$];
    fifo_host_pkg::line_t pend_data [$];
    int pend_due [$];
    fifo_host_pkg::ring_idx_t req_idx;
    int req_total;
    int consumed_lines;
    logic stall_prev;
    fifo_host_pkg::chunk_t data_prev;

    fifo_host_top #(.SB_ENTRIES(SB_DEPTH)) fifo_host_top_inst
    (
        .clk          (clk),
        .resetb       (resetb),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack),
        .rd_req       (rd_req),
        .rd_grant     (rd_grant),
        .rd_addr      (rd_addr),
        .rd_tag       (rd_tag),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_tag   (rd_rsp_tag),
        .rd_rsp_data  (rd_rsp_data),
        .rx_data      (rx_data),
        .rx_rdy       (rx_rdy),
        .rx_enable    (rx_enable)
    );

    always #50 clk = ~clk;

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            report_error("value mismatch");
        end
    endtask

    // Hold the strobe until the slave acks, then release the bus
    task automatic wait_for_ack;
        int waited;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
            if (waited > WB_TIMEOUT)
                report_error("Wishbone slave never raised wb_ack");
        end
        while (!wb_ack);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic write_reg(input fifo_host_pkg::wb_addr_t addr,
                             input fifo_host_pkg::wb_data_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= addr;
        wb_dat_i <= data;
        wait_for_ack();
    endtask

    task automatic read_reg(input fifo_host_pkg::wb_addr_t addr,
                            output fifo_host_pkg::wb_data_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= addr;
        wait_for_ack();
        data = wb_dat_o;
    endtask

    // Header chunk first, then the payload, padded out to a whole line
    task automatic build_messages;
        fifo_host_pkg::chunk_t chunks [16];
        fifo_host_pkg::line_t line;
        int n;
        int nl;
        total_lines = 0;
        for (int m = 0; m < NUM_MSGS; m++)
        begin
            n = 1 + int'($unsigned($random(seed)) % MAX_PAYLOAD);
            nl = (n + 4) / 4;
            msg_len[m] = nl;
            chunks[0] = {16'($random(seed)), 16'(n)};
            for (int k = 1; k < nl * 4; k++)
            begin
                chunks[k] = $random(seed);
                if (k <= n)
                begin
                    exp_chunk.push_back(chunks[k]);
                    exp_line.push_back(total_lines + k / 4);
                end
            end
            for (int l = 0; l < nl; l++)
            begin
                line = '0;
                for (int p = 0; p < fifo_host_pkg::CHUNKS_PER_LINE; p++)
                    line[32*p +: 32] = chunks[4*l + p];
                all_lines.push_back(line);
            end
            total_lines += nl;
        end
    endtask

    task automatic check_registers;
        fifo_host_pkg::wb_data_t rdata;
        for (int a = 0; a < 8; a++)
        begin
            read_reg(fifo_host_pkg::wb_addr_t'(a), rdata);
            check_value($sformatf("wb_dat_o reg %0d after reset", a), rdata, 0);
        end
        write_reg(fifo_host_pkg::REG_BASE, base_val);
        read_reg(fifo_host_pkg::REG_BASE, rdata);
        check_value("wb_dat_o BASE", rdata, base_val);
        write_reg(fifo_host_pkg::REG_NEWEST, 32'h2a);
        read_reg(fifo_host_pkg::REG_NEWEST, rdata);
        check_value("wb_dat_o NEWEST", rdata, 32'h2a);
        write_reg(fifo_host_pkg::REG_NEWEST, 32'h0);
        read_reg(fifo_host_pkg::REG_NEWEST, rdata);
        check_value("wb_dat_o NEWEST", rdata, 32'h0);
        // Status registers must ignore writes
        write_reg(fifo_host_pkg::REG_OLDEST, 32'h15);
        read_reg(fifo_host_pkg::REG_OLDEST, rdata);
        check_value("wb_dat_o OLDEST", rdata, 32'h0);
        write_reg(fifo_host_pkg::REG_REQ_COUNT, 32'h1234);
        read_reg(fifo_host_pkg::REG_REQ_COUNT, rdata);
        check_value("wb_dat_o REQ_COUNT", rdata, 32'h0);
        write_reg(fifo_host_pkg::REG_CTRL, 32'h1);
        read_reg(fifo_host_pkg::REG_CTRL, rdata);
        check_value("wb_dat_o CTRL", rdata, 32'h1);
    endtask

    // One slot always stays empty so that NEWEST equal to OLDEST means empty
    task automatic wait_for_ring_space(input int needed);
        fifo_host_pkg::wb_data_t rdata;
        fifo_host_pkg::ring_idx_t used;
        do
        begin
            read_reg(fifo_host_pkg::REG_OLDEST, rdata);
            used = wr_idx - fifo_host_pkg::ring_idx_t'(rdata);
        end
        while (int'(used) + needed > 63);
    endtask

    task automatic hold_paused;
        int waited;
        repeat (PAUSE_CYCLES)
        begin
            @(posedge clk);
            check_value("rd_req", rd_req, 1'b0);
        end
        write_reg(fifo_host_pkg::REG_CTRL, 32'h1);
        waited = 0;
        while (!rd_req)
        begin
            @(posedge clk);
            waited++;
            if (waited > RESUME_TIMEOUT)
                report_error("requests did not resume after CTRL was set again");
        end
    endtask

    task automatic run_messages;
        int line_pos;
        line_pos = 0;
        for (int m = 0; m < NUM_MSGS; m++)
        begin
            wait_for_ring_space(msg_len[m]);
            if (m == PAUSE_MSG)
                write_reg(fifo_host_pkg::REG_CTRL, 32'h0);
            for (int j = 0; j < msg_len[m]; j++)
            begin
                host_mem[wr_idx] = all_lines[line_pos];
                wr_idx = wr_idx + 1'b1;
                line_pos++;
            end
            // Counted before the publish so the monitor never lags the DUT
            published_total += msg_len[m];
            write_reg(fifo_host_pkg::REG_NEWEST, {26'b0, wr_idx});
            if (m == PAUSE_MSG)
                hold_paused();
        end
    endtask

    // ==========================================================
    // Memory model, client model and stream monitor
    // ==========================================================

    always @(posedge clk)
    begin : memory_and_client
        int pick;
        int delay;
        if (!resetb)
        begin
            rd_rsp_valid <= 1'b0;
            grant_roll <= 1'b0;
            take_roll <= 1'b0;
        end
        else
        begin
            cycle = cycle + 1;

            // A stalled chunk has to stay on offer and sit still until it is taken
            if (stall_prev)
            begin
                check_value("rx_rdy", rx_rdy, 1'b1);
                check_value("rx_data", rx_data, data_prev);
            end
            stall_prev = rx_rdy && !rx_enable;
            data_prev = rx_data;

            if (rx_rdy && rx_enable)
            begin
                if (exp_chunk.size() == 0)
                    report_error("client received a chunk after the last payload");
                else
                begin
                    check_value("rx_data", rx_data, exp_chunk[0]);
                    consumed_lines = exp_line[0] + 1;
                    void'(exp_chunk.pop_front());
                    void'(exp_line.pop_front());
                end
            end

            if (rd_req && rd_grant)
            begin
                if (req_total >= published_total)
                    report_error("read request issued for the slot at NEWEST");
                else
                begin
                    check_value("rd_addr", rd_addr,
                                base_val + fifo_host_pkg::line_addr_t'(req_idx));
                    // Slots are handed out strictly in order
                    check_value("rd_tag", rd_tag, req_total % SB_DEPTH);
                    delay = 1 + int'($unsigned($random(seed)) % 8);
                    pend_tag.push_back(rd_tag);
                    pend_data.push_back(host_mem[req_idx]);
                    pend_due.push_back(cycle + delay);
                    req_idx = req_idx + 1'b1;
                    req_total = req_total + 1;
                    // At most one dequeued line can still be waiting for its first chunk
                    if (req_total - consumed_lines > SB_DEPTH + 1)
                        report_error("more reads outstanding than scoreboard slots");
                end
            end

            // Earliest due response goes out first, which scrambles the order
            pick = -1;
            for (int i = 0; i < pend_due.size(); i++)
                if (pend_due[i] <= cycle && (pick < 0 || pend_due[i] < pend_due[pick]))
                    pick = i;
            if (pick >= 0)
            begin
                rd_rsp_valid <= 1'b1;
                rd_rsp_tag <= pend_tag[pick];
                rd_rsp_data <= pend_data[pick];
                pend_tag.delete(pick);
                pend_data.delete(pick);
                pend_due.delete(pick);
            end
            else
                rd_rsp_valid <= 1'b0;

            grant_roll <= ($random(seed) & 3) != 0;
            take_roll <= ($random(seed) & 1) != 0;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_error("watchdog expired before all messages were delivered");
    end

    initial
    begin
        fifo_host_pkg::wb_data_t rdata;
        clk = 1'b0;
        resetb = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_i = '0;
        rd_rsp_valid = 1'b0;
        rd_rsp_tag = '0;
        rd_rsp_data = '0;
        grant_roll = 1'b0;
        take_roll = 1'b0;
        cycle = 0;
        seed = 46;
        wr_idx = '0;
        req_idx = '0;
        req_total = 0;
        published_total = 0;
        consumed_lines = 0;
        stall_prev = 1'b0;
        data_prev = '0;
        // Fill pattern carries the full slot index
        for (int i = 0; i < 64; i++)
            host_mem[i] = {4{32'h5a5a_0000 + i}};
        base_val = $random(seed);
        build_messages();

        repeat (10) @(posedge clk);
        resetb <= 1'b1;
        @(posedge clk);

        check_registers();
        run_messages();

        while (exp_chunk.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (pend_due.size() != 0)
            report_error("memory model still holds reads after the stream ended");

        read_reg(fifo_host_pkg::REG_OLDEST, rdata);
        check_value("wb_dat_o OLDEST", rdata, {26'b0, wr_idx});
        read_reg(fifo_host_pkg::REG_REQ_COUNT, rdata);
        check_value("wb_dat_o REQ_COUNT", rdata, total_lines);
        read_reg(fifo_host_pkg::REG_RSP_COUNT, rdata);
        check_value("wb_dat_o RSP_COUNT", rdata, total_lines);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
fifo_host_pkg.sv
fifo_host_csr.sv
fifo_host_scoreboard.sv
fifo_host_reader.sv
fifo_host_top.sv
fifo_host_props.sv
tb_fifo_host.sv

// ==== Makefile ====
# Verilator build and run for the ring buffer reader testbench

VERILATOR ?= verilator
TOP ?= tb_fifo_host
BUILD_DIR ?= obj_dir
FILELIST ?= files.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The exit status of the binary is the test result
run: $(BIN)
	$(BIN)

clean:
	rm -rf $(BUILD_DIR)
